//--- Bender.yml
package:
  name: vga_game

sources:
  - common/vga_pkg.sv
  - logic/vga_timing.sv
  - logic/mouse_constrainer.sv
  - background/draw_background.sv
  - cursor/cursor_overlay.sv
  - logic/vga_game_top.sv
  - target: test
    files:
      - verif/vga_game_tb.sv

//--- background/draw_background.sv
`timescale 1ns/1ps

module draw_background #(
  parameter vga_pkg::coord_t H_ACTIVE = 1024,
  parameter vga_pkg::coord_t V_ACTIVE = 768,
  parameter vga_pkg::coord_t BORDER   = 16
) (
  input  logic                 pclk,
  input  logic                 arst_n,
  input  vga_pkg::vga_timing_t timing_in,
  input  vga_pkg::game_mode_e  mode,
  output vga_pkg::vga_timing_t timing_out,
  output vga_pkg::rgb_t        rgb
);

  // inner edges of the right and bottom border bands
  localparam vga_pkg::coord_t H_EDGE = H_ACTIVE - BORDER;
  localparam vga_pkg::coord_t V_EDGE = V_ACTIVE - BORDER;

  logic          in_border;
  vga_pkg::rgb_t rgb_nxt;

  assign in_border = (timing_in.hcount < BORDER) ||
                     (timing_in.hcount >= H_EDGE) ||
                     (timing_in.vcount < BORDER) ||
                     (timing_in.vcount >= V_EDGE);

  // blanking is left to the overlay stage
  always_comb begin
    if (mode == vga_pkg::MODE_GAME) begin
      rgb_nxt = in_border ? vga_pkg::COLOR_BORDER : vga_pkg::COLOR_FIELD;
    end else begin
      rgb_nxt = vga_pkg::COLOR_MENU;
    end
  end

  // timing travels with the colour one cycle late
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      timing_out.hcount <= '0;
      timing_out.vcount <= '0;
      timing_out.hsync  <= 1'b1;
      timing_out.vsync  <= 1'b1;
      // idle bundle is blanked until the first raster position arrives
      timing_out.hblnk  <= 1'b1;
      timing_out.vblnk  <= 1'b1;
      rgb               <= vga_pkg::COLOR_BLACK;
    end else begin
      timing_out <= timing_in;
      rgb        <= rgb_nxt;
    end
  end

endmodule

//--- common/vga_pkg.sv
package vga_pkg;

  // raster coordinates and cursor positions
  typedef logic [11:0] coord_t;

  // one colour channel as driven to the DAC pins
  typedef logic [3:0] color4_t;

  // raster position with syncs (active low) and blanking flags
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
  } vga_timing_t;

  typedef struct packed {
    color4_t r;
    color4_t g;
    color4_t b;
  } rgb_t;

  // clamped top-left corner of the cursor square
  typedef struct packed {
    coord_t x;
    coord_t y;
  } cursor_t;

  typedef enum logic {
    MODE_MENU = 1'b0,
    MODE_GAME = 1'b1
  } game_mode_e;

  localparam rgb_t COLOR_MENU   = 12'h226;
  localparam rgb_t COLOR_BORDER = 12'hf80;
  localparam rgb_t COLOR_FIELD  = 12'h0a2;
  localparam rgb_t COLOR_CURSOR = 12'hfff;
  localparam rgb_t COLOR_BLACK  = 12'h000;

endpackage

//--- cursor/cursor_overlay.sv
`timescale 1ns/1ps

module cursor_overlay #(
  parameter vga_pkg::coord_t CURSOR_SIZE = 8
) (
  input  logic                 pclk,
  input  logic                 arst_n,
  input  vga_pkg::vga_timing_t timing,
  input  vga_pkg::rgb_t        bg,
  input  vga_pkg::cursor_t     cursor,
  output logic                 hs,
  output logic                 vs,
  output vga_pkg::color4_t     r,
  output vga_pkg::color4_t     g,
  output vga_pkg::color4_t     b
);

  vga_pkg::coord_t x_end;
  vga_pkg::coord_t y_end;
  logic            in_cursor;
  logic            blank;
  vga_pkg::rgb_t   pix_nxt;

  // square spans [x, x+size) by [y, y+size)
  assign x_end = cursor.x + CURSOR_SIZE;
  assign y_end = cursor.y + CURSOR_SIZE;

  assign in_cursor = (timing.hcount >= cursor.x) && (timing.hcount < x_end) &&
                     (timing.vcount >= cursor.y) && (timing.vcount < y_end);

  assign blank = timing.hblnk || timing.vblnk;

  always_comb begin
    if (blank) begin
      pix_nxt = vga_pkg::COLOR_BLACK;
    end else if (in_cursor) begin
      pix_nxt = vga_pkg::COLOR_CURSOR;
    end else begin
      pix_nxt = bg;
    end
  end

  // output pins registered, syncs idle high in reset
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      hs <= 1'b1;
      vs <= 1'b1;
      r  <= '0;
      g  <= '0;
      b  <= '0;
    end else begin
      hs <= timing.hsync;
      vs <= timing.vsync;
      r  <= pix_nxt.r;
      g  <= pix_nxt.g;
      b  <= pix_nxt.b;
    end
  end

endmodule

//--- logic/mouse_constrainer.sv
`timescale 1ns/1ps

module mouse_constrainer #(
  parameter vga_pkg::coord_t H_ACTIVE    = 1024,
  parameter vga_pkg::coord_t V_ACTIVE    = 768,
  parameter vga_pkg::coord_t BORDER      = 16,
  parameter vga_pkg::coord_t CURSOR_SIZE = 8
) (
  input  logic                 pclk,
  input  logic                 arst_n,
  input  logic                 game_button,
  input  logic                 menu_button,
  input  vga_pkg::coord_t      mouse_x,
  input  vga_pkg::coord_t      mouse_y,
  input  vga_pkg::vga_timing_t timing,
  output vga_pkg::game_mode_e  mode,
  output vga_pkg::cursor_t     cursor
);

  // menu lets the cursor roam the whole active area
  localparam vga_pkg::coord_t X_MAX_MENU = H_ACTIVE - CURSOR_SIZE;
  localparam vga_pkg::coord_t Y_MAX_MENU = V_ACTIVE - CURSOR_SIZE;
  // game keeps it inside the border
  localparam vga_pkg::coord_t X_MAX_GAME = H_ACTIVE - BORDER - CURSOR_SIZE;
  localparam vga_pkg::coord_t Y_MAX_GAME = V_ACTIVE - BORDER - CURSOR_SIZE;

  vga_pkg::game_mode_e mode_nxt;
  vga_pkg::coord_t     lim_lo;
  vga_pkg::coord_t     x_hi;
  vga_pkg::coord_t     y_hi;
  logic                frame_start;

  function automatic vga_pkg::coord_t clamp(
    input vga_pkg::coord_t val,
    input vga_pkg::coord_t lo,
    input vga_pkg::coord_t hi
  );
    if (val < lo) return lo;
    if (val > hi) return hi;
    return val;
  endfunction

  // game button wins when both are held
  always_comb begin
    mode_nxt = mode;
    if (game_button) begin
      mode_nxt = vga_pkg::MODE_GAME;
    end else if (menu_button) begin
      mode_nxt = vga_pkg::MODE_MENU;
    end
  end

  assign lim_lo      = (mode == vga_pkg::MODE_GAME) ? BORDER : '0;
  assign x_hi        = (mode == vga_pkg::MODE_GAME) ? X_MAX_GAME : X_MAX_MENU;
  assign y_hi        = (mode == vga_pkg::MODE_GAME) ? Y_MAX_GAME : Y_MAX_MENU;
  assign frame_start = (timing.hcount == '0) && (timing.vcount == '0);

  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      mode   <= vga_pkg::MODE_MENU;
      cursor <= '0;
    end else begin
      mode <= mode_nxt;
      // sample once per frame so the cursor never tears
      if (frame_start) begin
        cursor.x <= clamp(mouse_x, lim_lo, x_hi);
        cursor.y <= clamp(mouse_y, lim_lo, y_hi);
      end
    end
  end

endmodule

//--- logic/vga_game_top.sv
`timescale 1ns/1ps

module vga_game_top #(
  parameter vga_pkg::coord_t H_ACTIVE    = 1024,
  parameter vga_pkg::coord_t H_FP        = 24,
  parameter vga_pkg::coord_t H_SYNC      = 136,
  parameter vga_pkg::coord_t H_BP        = 160,
  parameter vga_pkg::coord_t V_ACTIVE    = 768,
  parameter vga_pkg::coord_t V_FP        = 3,
  parameter vga_pkg::coord_t V_SYNC      = 6,
  parameter vga_pkg::coord_t V_BP        = 29,
  parameter vga_pkg::coord_t BORDER      = 16,
  parameter vga_pkg::coord_t CURSOR_SIZE = 8
) (
  input  logic             pclk,
  input  logic             arst_n,
  input  logic             game_button,
  input  logic             menu_button,
  input  vga_pkg::coord_t  mouse_x,
  input  vga_pkg::coord_t  mouse_y,
  output logic             hs,
  output logic             vs,
  output vga_pkg::color4_t r,
  output vga_pkg::color4_t g,
  output vga_pkg::color4_t b
);

  vga_pkg::vga_timing_t timing_raw;
  vga_pkg::vga_timing_t timing_bg;
  vga_pkg::rgb_t        bg_rgb;
  vga_pkg::game_mode_e  mode;
  vga_pkg::cursor_t     cursor;

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) vga_timing_i (
    .pclk   (pclk),
    .arst_n (arst_n),
    .timing (timing_raw)
  );

  // decode: buttons and raw position to mode and clamped cursor
  mouse_constrainer #(
    .H_ACTIVE    (H_ACTIVE),
    .V_ACTIVE    (V_ACTIVE),
    .BORDER      (BORDER),
    .CURSOR_SIZE (CURSOR_SIZE)
  ) mouse_constrainer_i (
    .pclk        (pclk),
    .arst_n      (arst_n),
    .game_button (game_button),
    .menu_button (menu_button),
    .mouse_x     (mouse_x),
    .mouse_y     (mouse_y),
    .timing      (timing_raw),
    .mode        (mode),
    .cursor      (cursor)
  );

  draw_background #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .BORDER   (BORDER)
  ) draw_background_i (
    .pclk       (pclk),
    .arst_n     (arst_n),
    .timing_in  (timing_raw),
    .mode       (mode),
    .timing_out (timing_bg),
    .rgb        (bg_rgb)
  );

  // result stage drives the pins
  cursor_overlay #(
    .CURSOR_SIZE (CURSOR_SIZE)
  ) cursor_overlay_i (
    .pclk   (pclk),
    .arst_n (arst_n),
    .timing (timing_bg),
    .bg     (bg_rgb),
    .cursor (cursor),
    .hs     (hs),
    .vs     (vs),
    .r      (r),
    .g      (g),
    .b      (b)
  );

endmodule

//--- logic/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter vga_pkg::coord_t H_ACTIVE = 1024,
  parameter vga_pkg::coord_t H_FP     = 24,
  parameter vga_pkg::coord_t H_SYNC   = 136,
  parameter vga_pkg::coord_t H_BP     = 160,
  parameter vga_pkg::coord_t V_ACTIVE = 768,
  parameter vga_pkg::coord_t V_FP     = 3,
  parameter vga_pkg::coord_t V_SYNC   = 6,
  parameter vga_pkg::coord_t V_BP     = 29
) (
  input  logic                 pclk,
  input  logic                 arst_n,
  output vga_pkg::vga_timing_t timing
);

  // sync window edges and line / frame totals
  localparam vga_pkg::coord_t HS_START = H_ACTIVE + H_FP;
  localparam vga_pkg::coord_t HS_END   = HS_START + H_SYNC;
  localparam vga_pkg::coord_t H_TOTAL  = HS_END + H_BP;
  localparam vga_pkg::coord_t VS_START = V_ACTIVE + V_FP;
  localparam vga_pkg::coord_t VS_END   = VS_START + V_SYNC;
  localparam vga_pkg::coord_t V_TOTAL  = VS_END + V_BP;

  vga_pkg::coord_t hcount_nxt;
  vga_pkg::coord_t vcount_nxt;

  // full timing bundle for one raster position
  function automatic vga_pkg::vga_timing_t raster_at(
    input vga_pkg::coord_t h,
    input vga_pkg::coord_t v
  );
    vga_pkg::vga_timing_t t;
    t.hcount = h;
    t.vcount = v;
    t.hsync  = !((h >= HS_START) && (h < HS_END));
    t.vsync  = !((v >= VS_START) && (v < VS_END));
    t.hblnk  = (h >= H_ACTIVE);
    t.vblnk  = (v >= V_ACTIVE);
    return t;
  endfunction

  // horizontal counter, vertical steps on line wrap
  always_comb begin
    hcount_nxt = timing.hcount + 1'b1;
    vcount_nxt = timing.vcount;
    if (timing.hcount == H_TOTAL - 1'b1) begin
      hcount_nxt = '0;
      if (timing.vcount == V_TOTAL - 1'b1) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = timing.vcount + 1'b1;
      end
    end
  end

  // counts and flags all change on the same edge
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      timing <= raster_at('0, '0);
    end else begin
      timing <= raster_at(hcount_nxt, vcount_nxt);
    end
  end

endmodule

//--- verif/vga_game_tb.sv
`timescale 1ns/1ps

module vga_game_tb;

  // tiny screen so one frame is about a thousand clocks
  localparam int H_ACT = 32;
  localparam int H_FP = 2;
  localparam int H_SYNC = 4;
  localparam int H_BP = 2;
  localparam int V_ACT = 24;
  localparam int V_FP = 1;
  localparam int V_SYNC = 2;
  localparam int V_BP = 1;
  localparam int BORDER = 4;
  localparam int CUR = 4;
  localparam int H_TOT = H_ACT + H_FP + H_SYNC + H_BP;
  localparam int FRAME = H_TOT * (V_ACT + V_FP + V_SYNC + V_BP);
  localparam int FRAMES = 36;
  localparam int TIMEOUT_NS = (FRAMES + 5) * FRAME * 4;

  logic pclk = 1'b0;
  logic arst_n = 1'b0;
  logic game_button = 1'b0;
  logic menu_button = 1'b0;
  vga_pkg::coord_t mouse_x = '0;
  vga_pkg::coord_t mouse_y = '0;
  logic hs, vs;
  vga_pkg::color4_t r, g, b;

  // shadow of raw raster position, mode and sampled cursor
  int pos = 0;
  vga_pkg::game_mode_e sh_mode = vga_pkg::MODE_MENU;
  vga_pkg::cursor_t sh_cur = '0;
  // expected {hs, vs, rgb} for the last two raster positions
  logic [13:0] exp_now = '0;
  logic [13:0] exp_old = '0;
  logic [1:0] valid = '0;
  int err_count = 0;
  int pass_tests = 0;
  int fail_tests = 0;
  int errs_before = 0;
  int sel;
  int unsigned seed = 32'hab26_e7d1;

  vga_game_top #(
    .H_ACTIVE (H_ACT), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
    .V_ACTIVE (V_ACT), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
    .BORDER (BORDER), .CURSOR_SIZE (CUR)
  ) vga_game_top_i (
    .pclk (pclk), .arst_n (arst_n), .game_button (game_button),
    .menu_button (menu_button), .mouse_x (mouse_x), .mouse_y (mouse_y),
    .hs (hs), .vs (vs), .r (r), .g (g), .b (b)
  );

  always #2 pclk = ~pclk;

  function automatic vga_pkg::coord_t clamp_coord(input int val, input int lo, input int hi);
    if (val < lo) return lo;
    if (val > hi) return hi;
    return val;
  endfunction

  // game mode pulls both limits in by the border width
  function automatic vga_pkg::cursor_t clamp_cursor(input int mx, input int my,
                                                    input vga_pkg::game_mode_e md);
    vga_pkg::cursor_t c;
    int lo;
    lo = (md == vga_pkg::MODE_GAME) ? BORDER : 0;
    c.x = clamp_coord(mx, lo, H_ACT - lo - CUR);
    c.y = clamp_coord(my, lo, V_ACT - lo - CUR);
    return c;
  endfunction

  // expected pins for one raster position
  function automatic logic [13:0] ref_pixel(input int h, input int v,
                                            input vga_pkg::game_mode_e md,
                                            input vga_pkg::cursor_t cur);
    logic hs_e, vs_e;
    vga_pkg::rgb_t pix;
    hs_e = !(h >= H_ACT + H_FP && h < H_ACT + H_FP + H_SYNC);
    vs_e = !(v >= V_ACT + V_FP && v < V_ACT + V_FP + V_SYNC);
    if (h >= H_ACT || v >= V_ACT)
      pix = vga_pkg::COLOR_BLACK;
    else if (h >= cur.x && h < cur.x + CUR && v >= cur.y && v < cur.y + CUR)
      pix = vga_pkg::COLOR_CURSOR;
    else if (md == vga_pkg::MODE_MENU)
      pix = vga_pkg::COLOR_MENU;
    else if (h < BORDER || h >= H_ACT - BORDER || v < BORDER || v >= V_ACT - BORDER)
      pix = vga_pkg::COLOR_BORDER;
    else
      pix = vga_pkg::COLOR_FIELD;
    return {hs_e, vs_e, pix};
  endfunction

  // model steps on the rising edge while inputs are stable
  always @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      pos = 0;
      sh_mode = vga_pkg::MODE_MENU;
      sh_cur = '0;
      valid = '0;
    end else begin
      if (pos == 0)
        sh_cur = clamp_cursor(mouse_x, mouse_y, sh_mode);
      exp_old = exp_now;
      exp_now = ref_pixel(pos % H_TOT, pos / H_TOT, sh_mode, sh_cur);
      valid = {valid[0], 1'b1};
      if (game_button)
        sh_mode = vga_pkg::MODE_GAME;
      else if (menu_button)
        sh_mode = vga_pkg::MODE_MENU;
      pos = (pos + 1) % FRAME;
    end
  end

  // pins lag the raw count by two clocks
  always @(negedge pclk) begin
    if (arst_n && valid[1] && {hs, vs, r, g, b} !== exp_old) begin
      $display("[FAIL] %0d ns: pixel mismatch, pins %h expected %h",
               $time, {hs, vs, r, g, b}, exp_old);
      err_count++;
    end
  end

  task automatic wait_frames(input int n);
    repeat (n * FRAME) @(negedge pclk);
  endtask

  task automatic wait_pos(input int p);
    do begin
      @(negedge pclk);
    end while (pos != p);
  endtask

  task automatic set_mouse(input int x, input int y);
    @(negedge pclk);
    mouse_x = vga_pkg::coord_t'(x);
    mouse_y = vga_pkg::coord_t'(y);
  endtask

  task automatic pulse_buttons(input logic game, input logic menu);
    @(negedge pclk);
    game_button = game;
    menu_button = menu;
    @(negedge pclk);
    game_button = 1'b0;
    menu_button = 1'b0;
  endtask

  task automatic report_test(input string name);
    @(posedge pclk);
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
    errs_before = err_count;
  endtask

  initial begin
    void'($urandom(seed));
    repeat (8) begin
      @(negedge pclk);
      if (hs !== 1'b1 || vs !== 1'b1 || {r, g, b} !== 12'h000) begin
        $display("[FAIL] %0d ns: pins not at their reset values", $time);
        err_count++;
      end
    end
    arst_n = 1'b1;
    // first edge after release still carries the pipeline fill
    @(negedge pclk);
    if (hs !== 1'b1 || vs !== 1'b1 || {r, g, b} !== 12'h000) begin
      $display("[FAIL] %0d ns: pins not idle right after reset", $time);
      err_count++;
    end
    wait_frames(1);
    repeat (2) @(negedge pclk);
    report_test("reset and raster");

    set_mouse($urandom % (H_ACT - CUR + 1), $urandom % (V_ACT - CUR + 1));
    wait_frames(2);
    report_test("menu background and cursor");

    pulse_buttons(1'b1, 1'b0);
    wait_frames(2);
    set_mouse(0, 0);
    wait_frames(2);
    set_mouse(4095, 4095);
    wait_frames(2);
    report_test("game mode clamping");

    pulse_buttons(1'b0, 1'b1);
    wait_frames(2);
    // game has priority when both are held
    pulse_buttons(1'b1, 1'b1);
    wait_frames(2);
    report_test("return to menu");

    repeat (20) begin
      wait_pos(FRAME / 2);
      set_mouse($urandom % 40, $urandom % 32);
      sel = $urandom % 3;
      if (sel == 0)
        pulse_buttons(1'b1, 1'b0);
      else if (sel == 1)
        pulse_buttons(1'b0, 1'b1);
    end
    wait_frames(1);
    report_test("per-frame sampling");

    $display("tests: %0d passed, %0d failed", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns before all tests finished", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
common/vga_pkg.sv
logic/vga_timing.sv
logic/mouse_constrainer.sv
background/draw_background.sv
cursor/cursor_overlay.sv
logic/vga_game_top.sv
verif/vga_game_tb.sv
